// ==== verilog/id_pkg.sv ====
`default_nettype none

package id_pkg;

  // ------------------------------
  // Widths
  // ------------------------------
  localparam int INSTR_W  = 32;
  localparam int CINSTR_W = 16;
  localparam int REG_W    = 5;

  // Major opcodes of the supported RV32I subset
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;

  // Recognized funct codes
  localparam logic [2:0] F3_ADD = 3'b000;
  localparam logic [2:0] F3_W   = 3'b010;
  localparam logic [2:0] F3_BEQ = 3'b000;
  localparam logic [2:0] F3_BNE = 3'b001;
  localparam logic [6:0] F7_ADD = 7'b0000000;
  localparam logic [6:0] F7_SUB = 7'b0100000;

  // Architectural register numbers
  localparam logic [REG_W-1:0] REG_RA = 5'd1;
  localparam logic [REG_W-1:0] REG_SP = 5'd2;
  localparam logic [REG_W-1:0] REG_S0 = 5'd8;
  localparam logic [REG_W-1:0] REG_S1 = 5'd9;
  localparam logic [REG_W-1:0] REG_S2 = 5'd18;

  // cm.push with one to four saved registers
  localparam int PUSH_BASE_ADJ = 16;
  localparam int MAX_PUSH_REGS = 4;

  // ------------------------------
  // Issue entry
  // ------------------------------
  typedef enum logic [2:0] {
    FU_NONE, FU_ALU, FU_LOAD, FU_STORE, FU_CTRL
  } fu_e;

  typedef enum logic {
    OP_ADD, OP_SUB
  } alu_op_e;

  typedef struct packed {
    fu_e                fu;
    alu_op_e            op;
    logic [REG_W-1:0]   rd;
    logic [REG_W-1:0]   rs1;
    logic [REG_W-1:0]   rs2;
    logic [31:0]        imm;
    logic               use_imm;
    logic               illegal;
    logic               is_compressed;
    logic [INSTR_W-1:0] pc;
  } issue_entry_t;

endpackage

`default_nettype wire

// ==== verilog/decode_ifs.sv ====
`timescale 1ns/1ps
`default_nettype none

// Expanded instruction from the compressed expander to the macro FSM
interface expand_if import id_pkg::*; ();
  logic [INSTR_W-1:0]               instr;
  logic                             is_compressed;
  logic                             illegal;
  logic                             is_push;
  // Number of saved registers minus one
  logic [$clog2(MAX_PUSH_REGS)-1:0] rlist;
  logic [1:0]                       spimm;

  modport source (
    output instr, is_compressed, illegal, is_push, rlist, spimm
  );
  modport sink (
    input instr, is_compressed, illegal, is_push, rlist, spimm
  );
endinterface

// Current micro-op toward decode and the pipeline register
interface uop_if import id_pkg::*; ();
  logic [INSTR_W-1:0] instr;
  logic               is_compressed;
  logic               illegal;
  // Final micro-op of the fetch entry
  logic               last;

  modport source (
    output instr, is_compressed, illegal, last
  );
  modport sink (
    input instr, is_compressed, illegal, last
  );
endinterface

`default_nettype wire

// ==== verilog/compressed_expander.sv ====
`timescale 1ns/1ps
`default_nettype none

module compressed_expander import id_pkg::*; (
  input  logic [INSTR_W-1:0] fetch_instr_i,
  expand_if.source           exp
);

  logic [CINSTR_W-1:0] c;
  logic [11:0]         c_imm;
  logic [REG_W-1:0]    c_rd;
  logic [REG_W-1:0]    c_rs2;
  logic                is_cm_push;

  assign c     = fetch_instr_i[CINSTR_W-1:0];
  // CI-format immediate, sign-extended to the I-type field
  assign c_imm = {{7{c[12]}}, c[6:2]};
  assign c_rd  = c[11:7];
  assign c_rs2 = c[6:2];

  // cm.push, register lists ra through s2 only (rlist 4 to 7)
  assign is_cm_push = (c[15:13] == 3'b101) && (c[12:8] == 5'b11000) &&
                      (c[7:6] == 2'b01) && (c[1:0] == 2'b10);

  always_comb begin
    exp.instr         = '0;
    exp.is_compressed = 1'b1;
    exp.illegal       = 1'b0;
    exp.is_push       = 1'b0;
    exp.rlist         = '0;
    exp.spimm         = '0;

    if (c[1:0] == 2'b11) begin
      // Full-size instruction
      exp.instr         = fetch_instr_i;
      exp.is_compressed = 1'b0;
    end else begin
      case ({c[15:13], c[1:0]})
        // C.ADDI
        5'b000_01: exp.instr = {c_imm, c_rd, F3_ADD, c_rd, OPC_OP_IMM};
        // C.LI
        5'b010_01: exp.instr = {c_imm, 5'd0, F3_ADD, c_rd, OPC_OP_IMM};
        5'b100_10: begin
          if (c_rs2 == '0) begin
            // c.jr, c.jalr and c.ebreak are not supported
            exp.illegal = 1'b1;
          end else if (c[12]) begin
            // C.ADD
            exp.instr = {F7_ADD, c_rs2, c_rd, F3_ADD, c_rd, OPC_OP};
          end else begin
            // C.MV
            exp.instr = {F7_ADD, c_rs2, 5'd0, F3_ADD, c_rd, OPC_OP};
          end
        end
        5'b101_10: begin
          if (is_cm_push) begin
            exp.is_push = 1'b1;
            exp.rlist   = c[5:4];
            exp.spimm   = c[3:2];
          end else begin
            exp.illegal = 1'b1;
          end
        end
        default: exp.illegal = 1'b1;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== verilog/macro_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

module macro_counter import id_pkg::*; (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  logic                             clear_i,
  input  logic                             step_i,
  output logic [$clog2(MAX_PUSH_REGS)-1:0] index_o
);

  logic [$clog2(MAX_PUSH_REGS)-1:0] index_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      index_q <= '0;
    end else if (clear_i) begin
      index_q <= '0;
    end else if (step_i) begin
      index_q <= index_q + 1'b1;
    end
  end

  assign index_o = index_q;

  // The FSM leaves the store phase before the index could wrap
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (step_i && !clear_i) |-> (index_q != 2'(MAX_PUSH_REGS - 1)));

endmodule

`default_nettype wire

// ==== verilog/macro_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module macro_fsm import id_pkg::*; (
  input  logic   clk_i,
  input  logic   rst_ni,
  input  logic   flush_i,
  input  logic   advance_i,
  expand_if.sink exp,
  uop_if.source  uop
);

  typedef enum logic [1:0] {IDLE, STORE, ADJUST} state_e;

  state_e                           state_q;
  state_e                           state_d;
  logic [$clog2(MAX_PUSH_REGS)-1:0] index;
  logic                             cnt_clear;
  logic                             cnt_step;
  logic                             push_store;
  logic [REG_W-1:0]                 store_reg;
  logic [11:0]                      store_off;
  logic [11:0]                      adj_imm;

  macro_counter i_macro_counter (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .clear_i(cnt_clear),
    .step_i (cnt_step),
    .index_o(index)
  );

  // Store phase of a push including its first cycle in IDLE
  assign push_store = (state_q == STORE) || ((state_q == IDLE) && exp.is_push);

  always_comb begin
    case (index)
      2'd0:    store_reg = REG_RA;
      2'd1:    store_reg = REG_S0;
      2'd2:    store_reg = REG_S1;
      default: store_reg = REG_S2;
    endcase
  end

  // sw reg, -4(k+1)(sp)
  assign store_off = 12'd0 - ({8'd0, index, 2'b00} + 12'd4);
  // addi sp, sp, -(16 + 16 * spimm)
  assign adj_imm   = 12'd0 - (12'(PUSH_BASE_ADJ) + {6'd0, exp.spimm, 4'd0});

  // ------------------------------
  // Micro-op generation
  // ------------------------------
  always_comb begin
    uop.instr         = exp.instr;
    uop.is_compressed = exp.is_compressed;
    uop.illegal       = exp.illegal;
    uop.last          = 1'b1;
    if (state_q == ADJUST) begin
      uop.instr = {adj_imm, REG_SP, F3_ADD, REG_SP, OPC_OP_IMM};
    end else if (push_store) begin
      uop.instr = {store_off[11:5], store_reg, REG_SP, F3_W, store_off[4:0], OPC_STORE};
      uop.last  = 1'b0;
    end
  end

  always_comb begin
    state_d   = state_q;
    cnt_clear = 1'b0;
    cnt_step  = 1'b0;
    case (state_q)
      IDLE, STORE: begin
        if (advance_i && push_store) begin
          if (index == exp.rlist) begin
            state_d   = ADJUST;
            cnt_clear = 1'b1;
          end else begin
            state_d  = STORE;
            cnt_step = 1'b1;
          end
        end
      end
      ADJUST: begin
        if (advance_i) state_d = IDLE;
      end
      default: state_d = IDLE;
    endcase
    // Abort a running sequence
    if (flush_i) begin
      state_d   = IDLE;
      cnt_clear = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // A running push keeps its fetch word on the input
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (state_q != IDLE) |-> exp.is_push);

endmodule

`default_nettype wire

// ==== verilog/instr_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module instr_decoder import id_pkg::*; (
  input  logic [INSTR_W-1:0] fetch_pc_i,
  uop_if.sink                uop,
  output issue_entry_t       entry_o,
  output logic               is_ctrl_flow_o
);

  logic [INSTR_W-1:0] instr;
  logic [6:0]         opcode;
  logic [2:0]         funct3;
  logic [6:0]         funct7;
  logic [31:0]        imm_i;
  logic [31:0]        imm_s;
  logic [31:0]        imm_b;
  logic [31:0]        imm_u;
  logic [31:0]        imm_j;
  logic               legal;
  logic               ctrl;
  issue_entry_t       dec;

  assign instr  = uop.instr;
  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  // Sign-extended immediates per format
  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};
  assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  always_comb begin
    dec     = '0;
    dec.fu  = FU_NONE;
    dec.op  = OP_ADD;
    legal   = 1'b1;
    ctrl    = 1'b0;
    case (opcode)
      OPC_OP_IMM: begin
        legal       = (funct3 == F3_ADD);
        dec.fu      = FU_ALU;
        dec.rd      = instr[11:7];
        dec.rs1     = instr[19:15];
        dec.imm     = imm_i;
        dec.use_imm = 1'b1;
      end
      OPC_OP: begin
        legal   = (funct3 == F3_ADD) && ((funct7 == F7_ADD) || (funct7 == F7_SUB));
        dec.fu  = FU_ALU;
        dec.op  = (funct7 == F7_SUB) ? OP_SUB : OP_ADD;
        dec.rd  = instr[11:7];
        dec.rs1 = instr[19:15];
        dec.rs2 = instr[24:20];
      end
      OPC_LOAD: begin
        legal       = (funct3 == F3_W);
        dec.fu      = FU_LOAD;
        dec.rd      = instr[11:7];
        dec.rs1     = instr[19:15];
        dec.imm     = imm_i;
        dec.use_imm = 1'b1;
      end
      OPC_STORE: begin
        legal       = (funct3 == F3_W);
        dec.fu      = FU_STORE;
        dec.rs1     = instr[19:15];
        dec.rs2     = instr[24:20];
        dec.imm     = imm_s;
        dec.use_imm = 1'b1;
      end
      OPC_LUI: begin
        dec.fu      = FU_ALU;
        dec.rd      = instr[11:7];
        dec.imm     = imm_u;
        dec.use_imm = 1'b1;
      end
      OPC_JAL: begin
        dec.fu      = FU_CTRL;
        dec.rd      = instr[11:7];
        dec.imm     = imm_j;
        dec.use_imm = 1'b1;
        ctrl        = 1'b1;
      end
      OPC_BRANCH: begin
        // Compare by subtraction
        legal   = (funct3 == F3_BEQ) || (funct3 == F3_BNE);
        dec.fu  = FU_CTRL;
        dec.op  = OP_SUB;
        dec.rs1 = instr[19:15];
        dec.rs2 = instr[24:20];
        dec.imm = imm_b;
        ctrl    = 1'b1;
      end
      default: legal = 1'b0;
    endcase

    if (!legal || uop.illegal) begin
      dec         = '0;
      dec.fu      = FU_NONE;
      dec.illegal = 1'b1;
      ctrl        = 1'b0;
    end
    dec.is_compressed = uop.is_compressed;
    dec.pc            = fetch_pc_i;
  end

  assign entry_o        = dec;
  assign is_ctrl_flow_o = ctrl;

endmodule

`default_nettype wire

// ==== verilog/issue_register.sv ====
`timescale 1ns/1ps
`default_nettype none

module issue_register import id_pkg::*; (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               flush_i,
  input  logic               fetch_valid_i,
  input  logic               issue_ack_i,
  input  issue_entry_t       entry_i,
  input  logic               is_ctrl_flow_i,
  input  logic [INSTR_W-1:0] fetch_instr_i,
  uop_if.sink                uop,
  output logic               advance_o,
  output logic               fetch_ready_o,
  output logic               issue_valid_o,
  output logic               is_ctrl_flow_o,
  output issue_entry_t       issue_entry_o,
  output logic [INSTR_W-1:0] orig_instr_o
);

  logic               valid_q;
  issue_entry_t       entry_q;
  logic [INSTR_W-1:0] orig_q;
  logic               ctrl_q;
  logic               take;

  // Register is empty, or its entry leaves this cycle
  assign take          = (!valid_q || issue_ack_i) && fetch_valid_i;
  assign advance_o     = take;
  // Fetch entry is consumed only with its final micro-op
  assign fetch_ready_o = take && uop.last;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else if (flush_i) begin
      valid_q <= 1'b0;
    end else if (take) begin
      valid_q <= 1'b1;
    end else if (issue_ack_i) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (take) begin
      entry_q <= entry_i;
      ctrl_q  <= is_ctrl_flow_i;
      orig_q  <= uop.is_compressed ?
                 {{(INSTR_W-CINSTR_W){1'b0}}, fetch_instr_i[CINSTR_W-1:0]} : fetch_instr_i;
    end
  end

  assign issue_valid_o  = valid_q;
  assign issue_entry_o  = entry_q;
  assign orig_instr_o   = orig_q;
  assign is_ctrl_flow_o = ctrl_q;

  // Issue acknowledges only a valid entry
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    issue_ack_i |-> issue_valid_o);

endmodule

`default_nettype wire

// ==== verilog/id_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module id_stage import id_pkg::*; (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               flush_i,
  input  logic [INSTR_W-1:0] fetch_instr_i,
  input  logic [INSTR_W-1:0] fetch_pc_i,
  input  logic               fetch_valid_i,
  output logic               fetch_ready_o,
  output issue_entry_t       issue_entry_o,
  output logic [INSTR_W-1:0] orig_instr_o,
  output logic               issue_valid_o,
  output logic               is_ctrl_flow_o,
  input  logic               issue_ack_i
);

  issue_entry_t decoded_entry;
  logic         decoded_ctrl_flow;
  logic         advance;

  expand_if i_expand_if ();
  uop_if    i_uop_if ();

  // ------------------------------
  // Expand, sequence, decode
  // ------------------------------
  compressed_expander i_compressed_expander (
    .fetch_instr_i(fetch_instr_i),
    .exp          (i_expand_if.source)
  );

  macro_fsm i_macro_fsm (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .flush_i  (flush_i),
    .advance_i(advance),
    .exp      (i_expand_if.sink),
    .uop      (i_uop_if.source)
  );

  instr_decoder i_instr_decoder (
    .fetch_pc_i    (fetch_pc_i),
    .uop           (i_uop_if.sink),
    .entry_o       (decoded_entry),
    .is_ctrl_flow_o(decoded_ctrl_flow)
  );

  // ID/issue pipeline register
  issue_register i_issue_register (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .flush_i       (flush_i),
    .fetch_valid_i (fetch_valid_i),
    .issue_ack_i   (issue_ack_i),
    .entry_i       (decoded_entry),
    .is_ctrl_flow_i(decoded_ctrl_flow),
    .fetch_instr_i (fetch_instr_i),
    .uop           (i_uop_if.sink),
    .advance_o     (advance),
    .fetch_ready_o (fetch_ready_o),
    .issue_valid_o (issue_valid_o),
    .is_ctrl_flow_o(is_ctrl_flow_o),
    .issue_entry_o (issue_entry_o),
    .orig_instr_o  (orig_instr_o)
  );

endmodule

`default_nettype wire

// ==== verification/tb_id_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_id_stage import id_pkg::*; ();

  localparam int CLK_PERIOD   = 4;
  localparam int RESET_CYCLES = 10;
  localparam int N_INSTR      = 400;

  typedef struct packed {
    issue_entry_t       entry;
    logic [INSTR_W-1:0] orig;
    logic               ctrl;
  } expect_t;

  logic               clk_i;
  logic               rst_ni;
  logic               flush_i;
  logic [INSTR_W-1:0] fetch_instr_i;
  logic [INSTR_W-1:0] fetch_pc_i;
  logic               fetch_valid_i;
  logic               fetch_ready_o;
  issue_entry_t       issue_entry_o;
  logic [INSTR_W-1:0] orig_instr_o;
  logic               issue_valid_o;
  logic               is_ctrl_flow_o;
  logic               issue_ack_i;

  logic [31:0]        lfsr;
  expect_t            exp_q[$];
  expect_t            head;
  logic               head_valid;
  int                 uops_left;
  int                 uops_total;
  int                 issued;
  int                 mid_push_flushes;
  logic [INSTR_W-1:0] next_pc;
  logic               take_q;
  logic               ack_q;
  logic               done;

  id_stage i_dut (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .flush_i       (flush_i),
    .fetch_instr_i (fetch_instr_i),
    .fetch_pc_i    (fetch_pc_i),
    .fetch_valid_i (fetch_valid_i),
    .fetch_ready_o (fetch_ready_o),
    .issue_entry_o (issue_entry_o),
    .orig_instr_o  (orig_instr_o),
    .issue_valid_o (issue_valid_o),
    .is_ctrl_flow_o(is_ctrl_flow_o),
    .issue_ack_i   (issue_ack_i)
  );

  // ------------------------------
  // Helpers
  // ------------------------------
  task automatic stop_on_error(input string line);
    $display("%s", line);
    $display("Regression failed");
    $fatal(1, "Stopped at the first error");
  endtask

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);
  endfunction

  // One LFSR step per bit taken
  function automatic logic [31:0] random_bits(input int n);
    logic [31:0] v;
    int          i;
    v = '0;
    for (i = 0; i < n; i++) begin
      v    = {v[30:0], lfsr[0]};
      lfsr = lfsr_step(lfsr);
    end
    return v;
  endfunction

  function automatic logic [31:0] sign_extend(input logic [31:0] v, input int w);
    logic signed [31:0] t;
    t = v << (32 - w);
    return t >>> (32 - w);
  endfunction

  function automatic issue_entry_t make_entry(input fu_e fu, input alu_op_e op,
                                              input logic [4:0] rd, input logic [4:0] rs1,
                                              input logic [4:0] rs2, input logic [31:0] imm,
                                              input logic use_imm);
    issue_entry_t e;
    e         = '0;
    e.fu      = fu;
    e.op      = op;
    e.rd      = rd;
    e.rs1     = rs1;
    e.rs2     = rs2;
    e.imm     = imm;
    e.use_imm = use_imm;
    return e;
  endfunction

  function automatic issue_entry_t illegal_entry();
    issue_entry_t e;
    e         = '0;
    e.fu      = FU_NONE;
    e.illegal = 1'b1;
    return e;
  endfunction

  // Saved register order of cm.push
  function automatic logic [4:0] saved_reg(input int k);
    case (k)
      0:       return REG_RA;
      1:       return REG_S0;
      2:       return REG_S1;
      default: return REG_S2;
    endcase
  endfunction

  task automatic push_expect(input issue_entry_t e, input logic comp,
                             input logic [INSTR_W-1:0] orig, input logic ctrl);
    expect_t x;
    e.is_compressed = comp;
    e.pc            = fetch_pc_i;
    x.entry         = e;
    x.orig          = orig;
    x.ctrl          = ctrl;
    exp_q.push_back(x);
    uops_total++;
  endtask

  // ------------------------------
  // Instruction builder
  // ------------------------------
  task automatic build_fetch();
    logic [3:0]         kind;
    logic [4:0]         rd;
    logic [4:0]         rs1;
    logic [4:0]         rs2;
    logic [31:0]        raw;
    logic [15:0]        upper;
    logic [15:0]        cword;
    logic [INSTR_W-1:0] word;
    logic [2:0]         f3;
    logic               comp;
    logic               ctrl;
    issue_entry_t       e;
    int                 k;
    kind       = 4'(random_bits(4));
    rd         = 5'(random_bits(5));
    rs1        = 5'(random_bits(5));
    rs2        = 5'(random_bits(5));
    raw        = random_bits(32);
    upper      = 16'(random_bits(16));
    fetch_pc_i = next_pc;
    uops_total = 0;
    word       = '0;
    cword      = '0;
    comp       = 1'b0;
    ctrl       = 1'b0;
    e          = '0;
    case (kind)
      4'd0: begin
        word = {raw[11:0], rs1, F3_ADD, rd, OPC_OP_IMM};
        e    = make_entry(FU_ALU, OP_ADD, rd, rs1, 5'd0, sign_extend(raw, 12), 1'b1);
      end
      4'd1, 4'd2: begin
        word = {(kind == 4'd2) ? F7_SUB : F7_ADD, rs2, rs1, F3_ADD, rd, OPC_OP};
        e    = make_entry(FU_ALU, (kind == 4'd2) ? OP_SUB : OP_ADD, rd, rs1, rs2, '0, 1'b0);
      end
      4'd3: begin
        word = {raw[11:0], rs1, F3_W, rd, OPC_LOAD};
        e    = make_entry(FU_LOAD, OP_ADD, rd, rs1, 5'd0, sign_extend(raw, 12), 1'b1);
      end
      4'd4: begin
        word = {raw[11:5], rs2, rs1, F3_W, raw[4:0], OPC_STORE};
        e    = make_entry(FU_STORE, OP_ADD, 5'd0, rs1, rs2, sign_extend(raw, 12), 1'b1);
      end
      4'd5: begin
        word = {raw[19:0], rd, OPC_LUI};
        e    = make_entry(FU_ALU, OP_ADD, rd, 5'd0, 5'd0, {raw[19:0], 12'd0}, 1'b1);
      end
      4'd6: begin
        word = {raw[20], raw[10:1], raw[11], raw[19:12], rd, OPC_JAL};
        e    = make_entry(FU_CTRL, OP_ADD, rd, 5'd0, 5'd0,
                          sign_extend({raw[31:1], 1'b0}, 21), 1'b1);
        ctrl = 1'b1;
      end
      4'd7, 4'd8: begin
        // Branches compare by subtraction
        f3   = (kind == 4'd7) ? F3_BEQ : F3_BNE;
        word = {raw[12], raw[10:5], rs2, rs1, f3, raw[4:1], raw[11], OPC_BRANCH};
        e    = make_entry(FU_CTRL, OP_SUB, 5'd0, rs1, rs2,
                          sign_extend({raw[31:1], 1'b0}, 13), 1'b0);
        ctrl = 1'b1;
      end
      4'd9, 4'd10: begin
        // C.ADDI and C.LI
        cword = {(kind == 4'd9) ? 3'b000 : 3'b010, raw[5], rd, raw[4:0], 2'b01};
        e     = make_entry(FU_ALU, OP_ADD, rd, (kind == 4'd9) ? rd : 5'd0, 5'd0,
                           sign_extend(raw, 6), 1'b1);
        comp  = 1'b1;
      end
      4'd11, 4'd12: begin
        // C.MV and C.ADD, rs2 of zero is another instruction
        if (rs2 == '0)
          rs2 = 5'd1;
        cword = {3'b100, (kind == 4'd12), rd, rs2, 2'b10};
        e     = make_entry(FU_ALU, OP_ADD, rd, (kind == 4'd12) ? rd : 5'd0, rs2, '0, 1'b0);
        comp  = 1'b1;
      end
      4'd13: begin
        // cm.push of ra through s2, stores first then the sp adjust
        comp  = 1'b1;
        cword = {3'b101, 5'b11000, 2'b01, raw[1:0], raw[3:2], 2'b10};
        for (k = 0; k <= int'(raw[1:0]); k++) begin
          e = make_entry(FU_STORE, OP_ADD, 5'd0, REG_SP, saved_reg(k),
                         32'(-4 * (k + 1)), 1'b1);
          push_expect(e, 1'b1, {16'd0, cword}, 1'b0);
        end
        e = make_entry(FU_ALU, OP_ADD, REG_SP, REG_SP, 5'd0,
                       32'(-(PUSH_BASE_ADJ + 16 * int'(raw[3:2]))), 1'b1);
        push_expect(e, 1'b1, {16'd0, cword}, 1'b0);
      end
      4'd14: begin
        // Fence opcode, or an OP-IMM funct3 other than ADDI
        f3 = (raw[14:12] == 3'b000) ? 3'b100 : raw[14:12];
        if (raw[0])
          word = {raw[31:15], raw[14:12], raw[11:7], 7'b0001111};
        else
          word = {raw[31:15], f3, raw[11:7], OPC_OP_IMM};
        e = illegal_entry();
      end
      default: begin
        // Quadrant 0 holds no supported form
        cword = {raw[15:2], 2'b00};
        e     = illegal_entry();
        comp  = 1'b1;
      end
    endcase
    if (comp)
      word = {upper, cword};
    if (kind != 4'd13)
      push_expect(e, comp, comp ? {16'd0, cword} : word, ctrl);
    fetch_instr_i = word;
    next_pc       = next_pc + (comp ? 32'd2 : 32'd4);
    uops_left     = uops_total;
    issued++;
  endtask

  // ------------------------------
  // Per-cycle drive, on the falling edge
  // ------------------------------
  task automatic drive_inputs();
    if (flush_i) begin
      // Flushed entries never reach issue
      flush_i   = 1'b0;
      uops_left = 0;
      exp_q.delete();
    end else begin
      if (ack_q)
        exp_q.delete(0);
      if (take_q)
        uops_left--;
    end
    if (uops_left == 0) begin
      fetch_valid_i = 1'b0;
      if (issued < N_INSTR && random_bits(2) != 0) begin
        build_fetch();
        fetch_valid_i = 1'b1;
      end
    end
    // Fetch is dropped together with the flush
    if (uops_left > 0 && random_bits(4) == 0) begin
      if (uops_total > 1 && uops_left < uops_total)
        mid_push_flushes++;
      flush_i       = 1'b1;
      fetch_valid_i = 1'b0;
    end
    issue_ack_i = issue_valid_o && (random_bits(2) != 0);
    head_valid  = exp_q.size() > 0;
    if (head_valid)
      head = exp_q[0];
  endtask

  // Accepts and acks seen by the DUT at the rising edge
  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      take_q <= 1'b0;
      ack_q  <= 1'b0;
    end else begin
      take_q <= fetch_valid_i && (!issue_valid_o || issue_ack_i);
      ack_q  <= issue_valid_o && issue_ack_i;
    end
  end

  // ------------------------------
  // Checks
  // ------------------------------
  reset_state: assert property (@(posedge clk_i)
    $rose(rst_ni) |-> (!issue_valid_o && !fetch_ready_o))
    else stop_on_error("Issue valid or fetch ready high right after reset");

  entry_expected: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (issue_valid_o && issue_ack_i) |-> head_valid)
    else stop_on_error("Issue acknowledged an entry while none was expected");

  entry_matches: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (issue_valid_o && issue_ack_i && head_valid) |->
      (issue_entry_o == head.entry && orig_instr_o == head.orig &&
       is_ctrl_flow_o == head.ctrl))
    else stop_on_error($sformatf(
      "MISMATCH at %0t ns: entry %h orig %h ctrl %b, expected %h orig %h ctrl %b",
      $time, $sampled(issue_entry_o), $sampled(orig_instr_o), $sampled(is_ctrl_flow_o),
      head.entry, head.orig, head.ctrl));

  entry_holds: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (issue_valid_o && !issue_ack_i && !flush_i) |=>
      (issue_valid_o && $stable(issue_entry_o) && $stable(orig_instr_o)))
    else stop_on_error($sformatf("MISMATCH at %0t ns: entry changed without ack", $time));

  flush_clears: assert property (@(posedge clk_i) disable iff (!rst_ni)
    flush_i |=> !issue_valid_o)
    else stop_on_error($sformatf("MISMATCH at %0t ns: issue valid after flush", $time));

  // Fetch is consumed only with the last micro-op of its entry
  ready_on_last: assert property (@(posedge clk_i) disable iff (!rst_ni)
    fetch_ready_o == (fetch_valid_i && (!issue_valid_o || issue_ack_i) && uops_left == 1))
    else stop_on_error($sformatf("MISMATCH at %0t ns: fetch_ready_o is %b, %0d micro-ops left",
      $time, $sampled(fetch_ready_o), uops_left));

  // ------------------------------
  // Clock, stimulus and watchdog
  // ------------------------------
  initial begin : clock_gen
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  initial begin : stimulus
    lfsr             = 32'h5a63f9a6;
    rst_ni           = 1'b0;
    flush_i          = 1'b0;
    fetch_instr_i    = '0;
    fetch_pc_i       = '0;
    fetch_valid_i    = 1'b0;
    issue_ack_i      = 1'b0;
    head             = '0;
    head_valid       = 1'b0;
    uops_left        = 0;
    uops_total       = 0;
    issued           = 0;
    mid_push_flushes = 0;
    next_pc          = 32'h0000_1000;
    done             = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    while (!done) begin
      @(negedge clk_i);
      drive_inputs();
      done = (issued == N_INSTR) && (uops_left == 0) && (exp_q.size() == 0) &&
             !issue_valid_o && !flush_i;
    end
    if (mid_push_flushes == 0) begin
      stop_on_error("No flush arrived while a cm.push was running");
    end else begin
      $display("Regression passed");
      $finish;
    end
  end

  initial begin : watchdog
    #(CLK_PERIOD * (RESET_CYCLES + N_INSTR * 8 + 100));
    stop_on_error("Watchdog timeout, the run did not finish in time");
  end

endmodule

`default_nettype wire

// ==== project.f ====
verilog/id_pkg.sv
verilog/decode_ifs.sv
verilog/compressed_expander.sv
verilog/macro_counter.sv
verilog/macro_fsm.sv
verilog/instr_decoder.sv
verilog/issue_register.sv
verilog/id_stage.sv
verification/tb_id_stage.sv

// ==== Makefile ====
# Verilator build and regression run for the ID stage

VERILATOR ?= verilator
TOP       ?= tb_id_stage
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	$(SIM_BIN) | tee $(LOG)
	@grep -q "Regression passed" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
